// ==== Makefile ====
# Verilator build and run of the Sonata system bus testbench.

SIM  := obj_dir/Vtb_sonata_system
SRCS := $(wildcard hw/*.sv) $(wildcard dv/*.sv)

.PHONY: build run clean

build: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) sonata_system.f
	verilator --binary --assert -Wno-fatal --top-module tb_sonata_system \
	  -f sonata_system.f

# The run passes only when the log holds the pass line.
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_sonata_system.sv ====
// Testbench for the Sonata system bus.
// Drives the fetch and data hosts, keeps a RAM model and checks responses,
// arbitration, GPIO and timer behavior with assertions.

`timescale 1ns/1ps

module tb_sonata_system;

  localparam int unsigned Timeout  = 50;
  localparam int unsigned NumWords = 16;

  logic                 clk;
  logic                 reset;
  logic                 fetch_req;
  logic [31:0]          fetch_addr;
  logic                 fetch_gnt;
  logic                 fetch_rvalid;
  sonata_pkg::bus_rsp_t fetch_rsp;
  logic                 data_req;
  sonata_pkg::bus_req_t data_bus;
  logic                 data_gnt;
  logic                 data_rvalid;
  sonata_pkg::bus_rsp_t data_rsp;
  logic [12:0]          gp_in;
  logic [11:0]          gp_out;
  logic                 timer_irq;

  int unsigned cycle_cnt = 0;
  int unsigned errors = 0;
  int unsigned errors_at_start = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  string       test_name = "reset";

  // RAM model keyed by byte address of the word.
  logic [31:0] ram_model [logic [31:0]];
  logic [31:0] word_addr [NumWords];

  sonata_system uut (
    .clk_sys_i     (clk),
    .reset_i       (reset),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .fetch_gnt_o   (fetch_gnt),
    .fetch_rvalid_o(fetch_rvalid),
    .fetch_rsp_o   (fetch_rsp),
    .data_req_i    (data_req),
    .data_bus_i    (data_bus),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_rsp_o    (data_rsp),
    .gp_i          (gp_in),
    .gp_o          (gp_out),
    .timer_irq_o   (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Checks and helpers.
  ////////////////////////////////////////////////////////////////////////////

  task automatic record_error(input string what);
    $display("Error in %s: %s", test_name, what);
    errors++;
  endtask

  task automatic check_word(input string item, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, item, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%-16s ok", test_name);
    end else begin
      tests_failed++;
      $display("%-16s failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // Byte lanes of new_word replace those of old_word where be is set.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // One transfer on one host. Returns the response and the grant cycle.
  task automatic bus_xfer(input bit is_fetch, input logic [31:0] addr, input logic we,
                          input logic [3:0] be, input logic [31:0] wdata,
                          output sonata_pkg::bus_rsp_t rsp, output int unsigned gnt_cycle);
    int unsigned waited;
    logic        granted;
    rsp = '0;
    gnt_cycle = 0;
    waited = 0;
    @(posedge clk);
    if (is_fetch) begin
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
    end else begin
      data_req <= 1'b1;
      data_bus <= '{addr, we, be, wdata, 1'b0};
    end
    @(negedge clk);
    while (!(is_fetch ? fetch_gnt : data_gnt) && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    granted = is_fetch ? fetch_gnt : data_gnt;
    gnt_cycle = cycle_cnt;
    @(posedge clk);
    fetch_req <= 1'b0;
    data_req  <= 1'b0;
    if (!granted) begin
      record_error("no grant arrived before the timeout");
      return;
    end
    waited = 0;
    @(negedge clk);
    while (!(is_fetch ? fetch_rvalid : data_rvalid) && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    if (is_fetch ? fetch_rvalid : data_rvalid) begin
      rsp = is_fetch ? fetch_rsp : data_rsp;
    end else begin
      record_error("no response arrived before the timeout");
    end
  endtask

  // Both hosts stream reads with req held. Fetch walks forwards and data backwards.
  task automatic alternate_reads();
    logic [31:0] fetch_exp[$];
    logic [31:0] data_exp[$];
    int unsigned fi, di, fdone, ddone, waited;
    logic        fg, dg;
    fi = 0;
    di = 0;
    fdone = 0;
    ddone = 0;
    waited = 0;
    @(posedge clk);
    fetch_req  <= 1'b1;
    fetch_addr <= word_addr[0];
    data_req   <= 1'b1;
    data_bus   <= '{word_addr[NumWords-1], 1'b0, 4'hf, 32'h0, 1'b0};
    while ((fdone < NumWords || ddone < NumWords) && waited < 4 * NumWords) begin
      @(negedge clk);
      waited++;
      if (fetch_rvalid && fetch_exp.size() > 0) begin
        check_word("fetch rdata", fetch_exp.pop_front(), fetch_rsp.rdata);
        fdone++;
      end
      if (data_rvalid && data_exp.size() > 0) begin
        check_word("data rdata", data_exp.pop_front(), data_rsp.rdata);
        ddone++;
      end
      fg = fetch_gnt;
      dg = data_gnt;
      if (fg) fetch_exp.push_back(ram_model[word_addr[fi]]);
      if (dg) data_exp.push_back(ram_model[word_addr[NumWords-1-di]]);
      @(posedge clk);
      if (fg) begin
        fi++;
        if (fi < NumWords) fetch_addr <= word_addr[fi];
        else fetch_req <= 1'b0;
      end
      if (dg) begin
        di++;
        if (di < NumWords) data_bus <= '{word_addr[NumWords-1-di], 1'b0, 4'hf, 32'h0, 1'b0};
        else data_req <= 1'b0;
      end
    end
    if (fdone < NumWords || ddone < NumWords) begin
      record_error("interleaved reads did not all complete before the timeout");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol assertions.
  ////////////////////////////////////////////////////////////////////////////

  gnt_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(fetch_gnt && data_gnt)) else record_error("both hosts granted in one cycle");
  fetch_rsp_follows: assert property (@(posedge clk) disable iff (reset)
    fetch_gnt |=> fetch_rvalid) else record_error("fetch rvalid missing after grant");
  data_rsp_follows: assert property (@(posedge clk) disable iff (reset)
    data_gnt |=> data_rvalid) else record_error("data rvalid missing after grant");
  fetch_rsp_only: assert property (@(posedge clk) disable iff (reset)
    fetch_rvalid |-> $past(fetch_gnt)) else record_error("fetch rvalid without a grant");
  data_rsp_only: assert property (@(posedge clk) disable iff (reset)
    data_rvalid |-> $past(data_gnt)) else record_error("data rvalid without a grant");
  // Waiting host goes next.
  fetch_then_data: assert property (@(posedge clk) disable iff (reset)
    (fetch_req && data_req && fetch_gnt) |=> data_gnt)
    else record_error("data host not granted after losing to fetch");
  data_then_fetch: assert property (@(posedge clk) disable iff (reset)
    (fetch_req && data_req && data_gnt) |=> fetch_gnt)
    else record_error("fetch host not granted after losing to data");

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    sonata_pkg::bus_rsp_t rsp;
    int unsigned          g1, g2, rise;
    logic [31:0]          value, m1, m2;
    logic [3:0]           be;
    logic [11:0]          gp_before;
    void'($urandom(55));
    reset      = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    data_req   = 1'b0;
    data_bus   = '0;
    gp_in      = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    start_test("reset_state");
    @(negedge clk);
    check_word("strobes", 32'h0, {28'h0, fetch_gnt, fetch_rvalid, data_gnt, data_rvalid});
    check_word("gp_o", 32'h0, 32'(gp_out));
    check_word("timer_irq_o", 32'h0, 32'(timer_irq));
    finish_test();

    start_test("ram_random");
    for (int i = 0; i < NumWords; i++) begin
      word_addr[i] = sonata_pkg::RamBase + i * 32'h40 + ($urandom % 16) * 4;
      value = $urandom;
      bus_xfer(1'b0, word_addr[i], 1'b1, 4'hf, value, rsp, g1);
      ram_model[word_addr[i]] = value;
    end
    for (int i = 0; i < NumWords; i++) begin
      value = $urandom;
      be = 4'($urandom);
      bus_xfer(1'b0, word_addr[i], 1'b1, be, value, rsp, g1);
      ram_model[word_addr[i]] = merge_bytes(ram_model[word_addr[i]], value, be);
    end
    for (int i = 0; i < NumWords; i++) begin
      bus_xfer(1'b0, word_addr[i], 1'b0, 4'hf, 32'h0, rsp, g1);
      check_word("rdata", ram_model[word_addr[i]], rsp.rdata);
      check_word("err", 32'h0, 32'(rsp.err));
    end
    finish_test();

    start_test("gpio");
    value = $urandom;
    bus_xfer(1'b0, sonata_pkg::GpioBase, 1'b1, 4'hf, value, rsp, g1);
    check_word("gp_o full", 32'(value[11:0]), 32'(gp_out));
    m1 = merge_bytes(32'(value[11:0]), 32'h0000_5a00, 4'b0010);
    bus_xfer(1'b0, sonata_pkg::GpioBase, 1'b1, 4'b0010, 32'h0000_5a00, rsp, g1);
    check_word("gp_o byte", 32'(m1[11:0]), 32'(gp_out));
    bus_xfer(1'b0, sonata_pkg::GpioBase, 1'b0, 4'hf, 32'h0, rsp, g1);
    check_word("gp_o readback", 32'(m1[11:0]), rsp.rdata);
    @(posedge clk);
    gp_in <= 13'($urandom);
    repeat (2) @(posedge clk);
    bus_xfer(1'b0, sonata_pkg::GpioBase + 32'(sonata_pkg::GpioInOffset), 1'b0, 4'hf, 32'h0,
             rsp, g1);
    check_word("gp_i read", 32'(gp_in), rsp.rdata);
    finish_test();

    start_test("fetch_region");
    bus_xfer(1'b1, word_addr[3], 1'b0, 4'hf, 32'h0, rsp, g1);
    check_word("ram rdata", ram_model[word_addr[3]], rsp.rdata);
    check_word("ram err", 32'h0, 32'(rsp.err));
    gp_before = gp_out;
    bus_xfer(1'b1, sonata_pkg::GpioBase, 1'b0, 4'hf, 32'h0, rsp, g1);
    check_word("gpio err", 32'h1, 32'(rsp.err));
    check_word("gpio rdata", 32'h0, rsp.rdata);
    check_word("gp_o kept", 32'(gp_before), 32'(gp_out));
    finish_test();

    start_test("interleaved");
    alternate_reads();
    finish_test();

    start_test("timer_unmapped");
    bus_xfer(1'b0, sonata_pkg::TimerBase, 1'b0, 4'hf, 32'h0, rsp, g1);
    m1 = rsp.rdata;
    repeat (7) @(posedge clk);
    bus_xfer(1'b0, sonata_pkg::TimerBase, 1'b0, 4'hf, 32'h0, rsp, g2);
    m2 = rsp.rdata;
    check_word("mtime delta", g2 - g1, m2 - m1);
    // The compare write is granted two cycles after this read.
    bus_xfer(1'b0, sonata_pkg::TimerBase, 1'b0, 4'hf, 32'h0, rsp, g1);
    bus_xfer(1'b0, sonata_pkg::TimerBase + 32'(sonata_pkg::TimerCmpOffset), 1'b1, 4'hf,
             rsp.rdata + 32'd22, rsp, g2);
    check_word("irq after write", 32'h0, 32'(timer_irq));
    while (!timer_irq && cycle_cnt - g2 < 40) @(negedge clk);
    rise = cycle_cnt - g2;
    if (!timer_irq) begin
      record_error("timer interrupt never rose");
    end else begin
      assert (rise >= 18 && rise <= 22) else begin
        $display("Fail %s irq delay: expected 18 to 22, actual %0d", test_name, rise);
        errors++;
      end
    end
    bus_xfer(1'b0, 32'h4000_0000, 1'b0, 4'hf, 32'h0, rsp, g1);
    check_word("unmapped err", 32'h1, 32'(rsp.err));
    check_word("unmapped rdata", 32'h0, rsp.rdata);
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/bus_arbiter.sv ====
// Bus arbiter.
// Shares the single system bus between the instruction-fetch host and the
// data load/store host. Grants are combinational and round-robin, and the
// one-cycle response is steered back to the host that was granted.

`timescale 1ns/1ps

module bus_arbiter (
  input  logic                 clk_sys_i,
  input  logic                 reset_i,

  input  logic                 fetch_req_i,
  input  sonata_pkg::bus_req_t fetch_bus_i,
  input  logic                 data_req_i,
  input  sonata_pkg::bus_req_t data_bus_i,

  output logic                 fetch_gnt_o,
  output logic                 data_gnt_o,

  output logic                 dev_req_o,
  output sonata_pkg::bus_req_t dev_bus_o,

  input  logic                 rsp_valid_i,
  output logic                 fetch_rvalid_o,
  output logic                 data_rvalid_o
);

  // Host that won the most recent grant.
  sonata_pkg::bus_host_e last_winner_q;
  sonata_pkg::bus_host_e winner;

  //////////////////////////////////////////////////////////////////////////
  // Grant selection.
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (fetch_req_i && data_req_i) begin
      // Both waiting, so the host that lost last time goes first.
      if (last_winner_q == sonata_pkg::HostFetch) begin
        winner = sonata_pkg::HostData;
      end else begin
        winner = sonata_pkg::HostFetch;
      end
    end else if (data_req_i) begin
      winner = sonata_pkg::HostData;
    end else begin
      winner = sonata_pkg::HostFetch;
    end
  end

  assign fetch_gnt_o = fetch_req_i & (winner == sonata_pkg::HostFetch);
  assign data_gnt_o  = data_req_i & (winner == sonata_pkg::HostData);

  // Winner's request goes to the decoder in the grant cycle.
  assign dev_req_o = fetch_req_i | data_req_i;
  assign dev_bus_o = (winner == sonata_pkg::HostData) ? data_bus_i : fetch_bus_i;

  // Updated on every grant. The decoder answers exactly one cycle after
  // the grant, so this also tells which host owns the response.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      last_winner_q <= sonata_pkg::HostData;
    end else if (dev_req_o) begin
      last_winner_q <= winner;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Response routing.
  //////////////////////////////////////////////////////////////////////////

  assign fetch_rvalid_o = rsp_valid_i & (last_winner_q == sonata_pkg::HostFetch);
  assign data_rvalid_o  = rsp_valid_i & (last_winner_q == sonata_pkg::HostData);

endmodule

// ==== hw/bus_decoder.sv ====
// Bus address decoder.
// Selects one of the RAM, GPIO and timer devices for each granted request,
// refuses fetches outside the RAM region and unclaimed addresses, and
// returns the registered device response one cycle later.

`timescale 1ns/1ps

module bus_decoder (
  input  logic                                clk_sys_i,
  input  logic                                reset_i,

  input  logic                                dev_req_i,
  input  sonata_pkg::bus_req_t                dev_bus_i,
  output logic                                rsp_valid_o,
  output sonata_pkg::bus_rsp_t                rsp_o,

  output logic                                ram_req_o,
  output logic                                gpio_req_o,
  output logic                                timer_req_o,
  input  logic [sonata_pkg::BusDataWidth-1:0] ram_rdata_i,
  input  logic [sonata_pkg::BusDataWidth-1:0] gpio_rdata_i,
  input  logic [sonata_pkg::BusDataWidth-1:0] timer_rdata_i
);

  sonata_pkg::bus_device_e dev_sel;
  sonata_pkg::bus_device_e sel_q;
  logic                    valid_q;

  // True when addr lies in [base, base + size).
  function automatic logic in_region(
    logic [sonata_pkg::BusAddrWidth-1:0] addr,
    logic [sonata_pkg::BusAddrWidth-1:0] base,
    int unsigned                         size
  );
    logic [sonata_pkg::BusAddrWidth-1:0] offset;
    offset = addr - base;
    return offset < size;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Address decode.
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (in_region(dev_bus_i.addr, sonata_pkg::RamBase, sonata_pkg::RamSize)) begin
      dev_sel = sonata_pkg::DevRam;
    end else if (dev_bus_i.instr) begin
      // Fetches only reach the RAM.
      dev_sel = sonata_pkg::DevNone;
    end else if (in_region(dev_bus_i.addr, sonata_pkg::GpioBase,
                           sonata_pkg::RegRegionSize)) begin
      dev_sel = sonata_pkg::DevGpio;
    end else if (in_region(dev_bus_i.addr, sonata_pkg::TimerBase,
                           sonata_pkg::RegRegionSize)) begin
      dev_sel = sonata_pkg::DevTimer;
    end else begin
      dev_sel = sonata_pkg::DevNone;
    end
  end

  assign ram_req_o   = dev_req_i & (dev_sel == sonata_pkg::DevRam);
  assign gpio_req_o  = dev_req_i & (dev_sel == sonata_pkg::DevGpio);
  assign timer_req_o = dev_req_i & (dev_sel == sonata_pkg::DevTimer);

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      sel_q   <= sonata_pkg::DevNone;
    end else begin
      valid_q <= dev_req_i;
      if (dev_req_i) begin
        sel_q <= dev_sel;
      end
    end
  end

  // Response mux. Errors carry zero data.
  always_comb begin
    rsp_o = '0;
    case (sel_q)
      sonata_pkg::DevRam:   rsp_o.rdata = ram_rdata_i;
      sonata_pkg::DevGpio:  rsp_o.rdata = gpio_rdata_i;
      sonata_pkg::DevTimer: rsp_o.rdata = timer_rdata_i;
      default:              rsp_o.err   = 1'b1;
    endcase
  end

  assign rsp_valid_o = valid_q;

endmodule

// ==== hw/gpio_regs.sv ====
// GPIO register block.
// One byte-writable output register driving gp_o, and an input register
// that samples gp_i every cycle for the bus to read.

`timescale 1ns/1ps

module gpio_regs (
  input  logic                                 clk_sys_i,
  input  logic                                 reset_i,

  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [sonata_pkg::BusByteEnable-1:0] be_i,
  input  logic [sonata_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [sonata_pkg::BusDataWidth-1:0]  wdata_i,
  output logic [sonata_pkg::BusDataWidth-1:0]  rdata_o,

  input  logic [sonata_pkg::GpiWidth-1:0]      gp_i,
  output logic [sonata_pkg::GpoWidth-1:0]      gp_o
);

  logic [sonata_pkg::GpiWidth-1:0]     gp_in_q;
  logic [sonata_pkg::BusDataWidth-1:0] gp_out_word;
  logic [sonata_pkg::BusDataWidth-1:0] gp_out_next;
  logic                                out_wr;

  // Output register viewed as a bus word.
  assign gp_out_word = {{(sonata_pkg::BusDataWidth - sonata_pkg::GpoWidth){1'b0}}, gp_o};
  assign gp_out_next = sonata_pkg::apply_be(gp_out_word, wdata_i, be_i);
  assign out_wr      = req_i & we_i & (addr_i == sonata_pkg::GpioOutOffset);

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      gp_o <= '0;
    end else if (out_wr) begin
      gp_o <= gp_out_next[sonata_pkg::GpoWidth-1:0];
    end
  end

  // Input sample, one per clock.
  always_ff @(posedge clk_sys_i) begin
    gp_in_q <= gp_i;
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (addr_i)
        sonata_pkg::GpioOutOffset: rdata_o <= gp_out_word;
        sonata_pkg::GpioInOffset:
          rdata_o <= {{(sonata_pkg::BusDataWidth - sonata_pkg::GpiWidth){1'b0}}, gp_in_q};
        default:                   rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== hw/sonata_pkg.sv ====
// Sonata system bus package.
// Bus widths, the fixed address map, device and host encodings and the
// request and response structs shared by the arbiter, decoder and devices.

package sonata_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Bus widths and address map.
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;

  // 16 KiB of word-wide RAM.
  localparam logic [BusAddrWidth-1:0] RamBase = 32'h0010_0000;
  localparam int unsigned RamSize      = 16 * 1024;
  localparam int unsigned RamDepth     = RamSize / 4;
  localparam int unsigned RamAddrWidth = $clog2(RamDepth);

  // Register regions, 4 KiB each.
  localparam logic [BusAddrWidth-1:0] GpioBase  = 32'h8000_0000;
  localparam logic [BusAddrWidth-1:0] TimerBase = 32'h8004_0000;
  localparam int unsigned RegRegionSize = 4 * 1024;
  localparam int unsigned RegAddrWidth  = 8;

  localparam int unsigned GpiWidth = 13;
  localparam int unsigned GpoWidth = 12;

  // Register offsets within a region.
  localparam logic [RegAddrWidth-1:0] GpioOutOffset    = 8'h00;
  localparam logic [RegAddrWidth-1:0] GpioInOffset     = 8'h04;
  localparam logic [RegAddrWidth-1:0] TimerMtimeOffset = 8'h00;
  localparam logic [RegAddrWidth-1:0] TimerCmpOffset   = 8'h04;

  //////////////////////////////////////////////////////////////////////////
  // Encodings and bus structs.
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DevRam,
    DevGpio,
    DevTimer,
    DevNone
  } bus_device_e;

  typedef enum logic {
    HostFetch,
    HostData
  } bus_host_e;

  typedef struct packed {
    logic [BusAddrWidth-1:0]  addr;
    logic                     we;
    logic [BusByteEnable-1:0] be;
    logic [BusDataWidth-1:0]  wdata;
    logic                     instr;
  } bus_req_t;

  typedef struct packed {
    logic [BusDataWidth-1:0] rdata;
    logic                    err;
  } bus_rsp_t;

  // Byte-enable merge of a write into an existing register word.
  function automatic logic [BusDataWidth-1:0] apply_be(
    logic [BusDataWidth-1:0]  old_word,
    logic [BusDataWidth-1:0]  new_word,
    logic [BusByteEnable-1:0] be
  );
    logic [BusDataWidth-1:0] merged;
    merged = old_word;
    for (int i = 0; i < BusByteEnable; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== hw/sonata_system.sv ====
// Sonata system bus top level.
// Connects the external fetch and data hosts through the round-robin
// arbiter and address decoder to the RAM, GPIO and timer devices.

`timescale 1ns/1ps

module sonata_system (
  input  logic                                clk_sys_i,
  input  logic                                reset_i,

  // Instruction fetch host.
  input  logic                                fetch_req_i,
  input  logic [sonata_pkg::BusAddrWidth-1:0] fetch_addr_i,
  output logic                                fetch_gnt_o,
  output logic                                fetch_rvalid_o,
  output sonata_pkg::bus_rsp_t                fetch_rsp_o,

  // Data load/store host.
  input  logic                                data_req_i,
  input  sonata_pkg::bus_req_t                data_bus_i,
  output logic                                data_gnt_o,
  output logic                                data_rvalid_o,
  output sonata_pkg::bus_rsp_t                data_rsp_o,

  input  logic [sonata_pkg::GpiWidth-1:0]     gp_i,
  output logic [sonata_pkg::GpoWidth-1:0]     gp_o,
  output logic                                timer_irq_o
);

  sonata_pkg::bus_req_t                fetch_bus;
  sonata_pkg::bus_req_t                dev_bus;
  sonata_pkg::bus_rsp_t                rsp;
  logic                                dev_req;
  logic                                rsp_valid;
  logic                                ram_req;
  logic                                gpio_req;
  logic                                timer_req;
  logic [sonata_pkg::BusDataWidth-1:0] ram_rdata;
  logic [sonata_pkg::BusDataWidth-1:0] gpio_rdata;
  logic [sonata_pkg::BusDataWidth-1:0] timer_rdata;

  // Fetches are full-word reads.
  always_comb begin
    fetch_bus       = '0;
    fetch_bus.addr  = fetch_addr_i;
    fetch_bus.we    = 1'b0;
    fetch_bus.be    = '1;
    fetch_bus.instr = 1'b1;
  end

  // Both hosts see the same response data.
  assign fetch_rsp_o = rsp;
  assign data_rsp_o  = rsp;

  //////////////////////////////////////////////////////////////////////////
  // Bus.
  //////////////////////////////////////////////////////////////////////////

  bus_arbiter u_arbiter (
    .clk_sys_i     (clk_sys_i),
    .reset_i       (reset_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_bus_i   (fetch_bus),
    .data_req_i    (data_req_i),
    .data_bus_i    (data_bus_i),
    .fetch_gnt_o   (fetch_gnt_o),
    .data_gnt_o    (data_gnt_o),
    .dev_req_o     (dev_req),
    .dev_bus_o     (dev_bus),
    .rsp_valid_i   (rsp_valid),
    .fetch_rvalid_o(fetch_rvalid_o),
    .data_rvalid_o (data_rvalid_o)
  );

  bus_decoder u_decoder (
    .clk_sys_i    (clk_sys_i),
    .reset_i      (reset_i),
    .dev_req_i    (dev_req),
    .dev_bus_i    (dev_bus),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  //////////////////////////////////////////////////////////////////////////
  // Devices.
  //////////////////////////////////////////////////////////////////////////

  sram_1p u_ram (
    .clk_sys_i(clk_sys_i),
    .req_i    (ram_req),
    .we_i     (dev_bus.we),
    .be_i     (dev_bus.be),
    .addr_i   (dev_bus.addr[sonata_pkg::RamAddrWidth+1:2]),
    .wdata_i  (dev_bus.wdata),
    .rdata_o  (ram_rdata)
  );

  gpio_regs u_gpio (
    .clk_sys_i(clk_sys_i),
    .reset_i  (reset_i),
    .req_i    (gpio_req),
    .we_i     (dev_bus.we),
    .be_i     (dev_bus.be),
    .addr_i   (dev_bus.addr[sonata_pkg::RegAddrWidth-1:0]),
    .wdata_i  (dev_bus.wdata),
    .rdata_o  (gpio_rdata),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i(clk_sys_i),
    .reset_i  (reset_i),
    .req_i    (timer_req),
    .we_i     (dev_bus.we),
    .be_i     (dev_bus.be),
    .addr_i   (dev_bus.addr[sonata_pkg::RegAddrWidth-1:0]),
    .wdata_i  (dev_bus.wdata),
    .rdata_o  (timer_rdata),
    .irq_o    (timer_irq_o)
  );

endmodule

// ==== hw/sram_1p.sv ====
// Single-port system RAM.
// Word-addressed storage with per-byte write enables. The addressed word
// is registered on every access, so a write returns the previous contents.

`timescale 1ns/1ps

module sram_1p (
  input  logic                                 clk_sys_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [sonata_pkg::BusByteEnable-1:0] be_i,
  input  logic [sonata_pkg::RamAddrWidth-1:0]  addr_i,
  input  logic [sonata_pkg::BusDataWidth-1:0]  wdata_i,
  output logic [sonata_pkg::BusDataWidth-1:0]  rdata_o
);

  logic [sonata_pkg::BusDataWidth-1:0] mem [sonata_pkg::RamDepth];

  //////////////////////////////////////////////////////////////////////////
  // Write port.
  //////////////////////////////////////////////////////////////////////////

  // One lane per byte enable.
  always_ff @(posedge clk_sys_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < sonata_pkg::BusByteEnable; i++) begin
        if (be_i[i]) begin
          mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Read port.
  //////////////////////////////////////////////////////////////////////////

  // Old word, read alongside any write in the same cycle.
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// ==== hw/timer_regs.sv ====
// Machine timer.
// Free-running 32-bit mtime counter and an mtimecmp compare register, both
// byte-writable from the bus, with a registered level interrupt raised
// while mtime is at or past mtimecmp.

`timescale 1ns/1ps

module timer_regs (
  input  logic                                 clk_sys_i,
  input  logic                                 reset_i,

  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [sonata_pkg::BusByteEnable-1:0] be_i,
  input  logic [sonata_pkg::RegAddrWidth-1:0]  addr_i,
  input  logic [sonata_pkg::BusDataWidth-1:0]  wdata_i,
  output logic [sonata_pkg::BusDataWidth-1:0]  rdata_o,

  output logic                                 irq_o
);

  logic [sonata_pkg::BusDataWidth-1:0] mtime_q;
  logic [sonata_pkg::BusDataWidth-1:0] mtimecmp_q;
  logic                                mtime_wr;
  logic                                cmp_wr;

  assign mtime_wr = req_i & we_i & (addr_i == sonata_pkg::TimerMtimeOffset);
  assign cmp_wr   = req_i & we_i & (addr_i == sonata_pkg::TimerCmpOffset);

  //////////////////////////////////////////////////////////////////////////
  // Counter and compare.
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else if (mtime_wr) begin
      // A write replaces this cycle's increment.
      mtime_q <= sonata_pkg::apply_be(mtime_q, wdata_i, be_i);
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Compare starts at its maximum so the interrupt stays quiet.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      mtimecmp_q <= '1;
    end else if (cmp_wr) begin
      mtimecmp_q <= sonata_pkg::apply_be(mtimecmp_q, wdata_i, be_i);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  // Register read-back.
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (addr_i)
        sonata_pkg::TimerMtimeOffset: rdata_o <= mtime_q;
        sonata_pkg::TimerCmpOffset:   rdata_o <= mtimecmp_q;
        default:                      rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== sonata_system.f ====
hw/sonata_pkg.sv
hw/sram_1p.sv
hw/gpio_regs.sv
hw/timer_regs.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/sonata_system.sv
dv/tb_sonata_system.sv
